// File: logic/rvIsaPkg.sv
package rvIsaPkg;

	// raw instruction width
	localparam int instrW = 32;

	typedef logic [instrW-1:0] instrT;

	// major opcodes, instr[6:0]
	localparam logic [6:0] opR      = 7'b0110011;
	localparam logic [6:0] opI      = 7'b0010011;
	localparam logic [6:0] opLoad   = 7'b0000011;
	localparam logic [6:0] opStore  = 7'b0100011;
	localparam logic [6:0] opBranch = 7'b1100011;
	localparam logic [6:0] opJal    = 7'b1101111;
	localparam logic [6:0] opJalr   = 7'b1100111;
	localparam logic [6:0] opLui    = 7'b0110111;

	// funct3, alu group
	// add also covers sub and addi
	localparam logic [2:0] f3Add = 3'b000;
	localparam logic [2:0] f3Sll = 3'b001;
	localparam logic [2:0] f3Slt = 3'b010;
	localparam logic [2:0] f3Xor = 3'b100;
	// srl and sra share this one
	localparam logic [2:0] f3Srl = 3'b101;
	localparam logic [2:0] f3Or  = 3'b110;
	localparam logic [2:0] f3And = 3'b111;

	// funct3, memory, word only
	localparam logic [2:0] f3Lw = 3'b010;
	localparam logic [2:0] f3Sw = 3'b010;

	// funct3, control flow
	localparam logic [2:0] f3Beq  = 3'b000;
	localparam logic [2:0] f3Bne  = 3'b001;
	localparam logic [2:0] f3Jalr = 3'b000;

	// funct7 marker for sub / sra
	localparam logic [6:0] funct7Alt = 7'b0100000;

	// halt pair
	// addi x1, x0, 12 then jalr x0, 0(x1)
	localparam instrT haltFirst  = 32'h00c00093;
	localparam instrT haltSecond = 32'h00008067;

endpackage

// File: logic/rvCorePkg.sv
package rvCorePkg;

	// datapath word width
	localparam int xLen = 32;

	// memory address width, both memories
	localparam int memAddrW = 12;

	// 32 architectural registers
	localparam int regIdxW = 5;

	// retired instruction counter width
	localparam int countW = 32;

	typedef logic [xLen-1:0] wordT;

	// byte address on the instruction side, word address on the data side
	typedef logic [memAddrW-1:0] memAddrT;

	typedef logic [regIdxW-1:0] regIdxT;

	typedef logic [countW-1:0] countT;

	// alu operations
	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluSll,
		aluSrl,
		aluSra,
		aluPassB
	} aluOpT;

	// write-back source select
	typedef enum logic [1:0] {
		wbAlu,
		wbMem,
		wbLink
	} wbSrcT;

endpackage

// File: logic/riscvDecode.sv
`timescale 1ns/1ps

module riscvDecode (
	input  rvIsaPkg::instrT   instr,
	output rvCorePkg::regIdxT rs1,
	output rvCorePkg::regIdxT rs2,
	output rvCorePkg::regIdxT rd,
	output rvCorePkg::wordT   imm,
	output rvCorePkg::aluOpT  aluOp,
	output logic              useImm,
	output logic              isLoad,
	output logic              isStore,
	output logic              isBranch,
	output logic              branchNe,
	output logic              isJal,
	output logic              isJalr,
	output logic              regWrite,
	output rvCorePkg::wbSrcT  wbSrc
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       altOp;

	// fixed field positions
	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign rd     = instr[11:7];
	assign altOp  = (funct7 == rvIsaPkg::funct7Alt);

	// immediate per format, all sign extended from bit 31
	always_comb begin
		case (opcode)
			rvIsaPkg::opStore:
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			rvIsaPkg::opBranch:
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			rvIsaPkg::opJal:
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			rvIsaPkg::opLui:
				imm = {instr[31:12], 12'b0};
			// I format, also loads and jalr
			default:
				imm = {{20{instr[31]}}, instr[31:20]};
		endcase
	end

	// control flags
	always_comb begin
		// no-op unless an opcode below claims it
		aluOp    = rvCorePkg::aluAdd;
		useImm   = 1'b0;
		isLoad   = 1'b0;
		isStore  = 1'b0;
		isBranch = 1'b0;
		branchNe = 1'b0;
		isJal    = 1'b0;
		isJalr   = 1'b0;
		regWrite = 1'b0;
		wbSrc    = rvCorePkg::wbAlu;
		case (opcode)
			rvIsaPkg::opR: begin
				regWrite = 1'b1;
				case (funct3)
					rvIsaPkg::f3Add: aluOp = altOp ? rvCorePkg::aluSub : rvCorePkg::aluAdd;
					rvIsaPkg::f3Sll: aluOp = rvCorePkg::aluSll;
					rvIsaPkg::f3Slt: aluOp = rvCorePkg::aluSlt;
					rvIsaPkg::f3Xor: aluOp = rvCorePkg::aluXor;
					rvIsaPkg::f3Srl: aluOp = altOp ? rvCorePkg::aluSra : rvCorePkg::aluSrl;
					rvIsaPkg::f3Or:  aluOp = rvCorePkg::aluOr;
					rvIsaPkg::f3And: aluOp = rvCorePkg::aluAnd;
					// sltu is left out
					default: regWrite = 1'b0;
				endcase
			end
			rvIsaPkg::opI: begin
				useImm   = 1'b1;
				regWrite = 1'b1;
				case (funct3)
					rvIsaPkg::f3Add: aluOp = rvCorePkg::aluAdd;
					rvIsaPkg::f3Slt: aluOp = rvCorePkg::aluSlt;
					rvIsaPkg::f3Xor: aluOp = rvCorePkg::aluXor;
					rvIsaPkg::f3Or:  aluOp = rvCorePkg::aluOr;
					rvIsaPkg::f3And: aluOp = rvCorePkg::aluAnd;
					// immediate shifts and sltiu not supported
					default: regWrite = 1'b0;
				endcase
			end
			rvIsaPkg::opLoad: begin
				// lw only, byte and half retire as no-op
				// immediate operand selected in the top level from isLoad
				if (funct3 == rvIsaPkg::f3Lw) begin
					isLoad   = 1'b1;
					regWrite = 1'b1;
					wbSrc    = rvCorePkg::wbMem;
				end
			end
			rvIsaPkg::opStore: begin
				if (funct3 == rvIsaPkg::f3Sw) begin
					useImm  = 1'b1;
					isStore = 1'b1;
				end
			end
			rvIsaPkg::opBranch: begin
				// compare happens in execute, alu unused here
				if (funct3 == rvIsaPkg::f3Beq || funct3 == rvIsaPkg::f3Bne) begin
					isBranch = 1'b1;
					branchNe = (funct3 == rvIsaPkg::f3Bne);
				end
			end
			rvIsaPkg::opJal: begin
				isJal    = 1'b1;
				regWrite = 1'b1;
				wbSrc    = rvCorePkg::wbLink;
			end
			rvIsaPkg::opJalr: begin
				if (funct3 == rvIsaPkg::f3Jalr) begin
					useImm   = 1'b1;
					isJalr   = 1'b1;
					regWrite = 1'b1;
					wbSrc    = rvCorePkg::wbLink;
				end
			end
			rvIsaPkg::opLui: begin
				// immediate straight through the alu
				useImm   = 1'b1;
				aluOp    = rvCorePkg::aluPassB;
				regWrite = 1'b1;
			end
			default: ;
		endcase
	end

endmodule

// File: logic/riscvExecute.sv
`timescale 1ns/1ps

module riscvExecute (
	input  logic               CLK,
	input  logic               RSTn,
	input  logic               halt,
	input  rvCorePkg::wordT    rs1Data,
	input  rvCorePkg::wordT    rs2Data,
	input  rvCorePkg::wordT    imm,
	input  rvCorePkg::aluOpT   aluOp,
	input  logic               useImm,
	input  logic               isBranch,
	input  logic               branchNe,
	input  logic               isJal,
	input  logic               isJalr,
	output rvCorePkg::wordT    pc,
	output rvCorePkg::wordT    aluResult,
	output rvCorePkg::wordT    linkAddr,
	output rvCorePkg::memAddrT iMemAddr,
	output rvCorePkg::memAddrT dMemAddr
);

	rvCorePkg::wordT operandB;
	rvCorePkg::wordT jalrTarget;
	rvCorePkg::wordT nextPc;
	logic            branchTaken;

	// operand b mux
	assign operandB = useImm ? imm : rs2Data;

	// alu
	always_comb begin
		case (aluOp)
			rvCorePkg::aluAdd:   aluResult = rs1Data + operandB;
			rvCorePkg::aluSub:   aluResult = rs1Data - operandB;
			rvCorePkg::aluAnd:   aluResult = rs1Data & operandB;
			rvCorePkg::aluOr:    aluResult = rs1Data | operandB;
			rvCorePkg::aluXor:   aluResult = rs1Data ^ operandB;
			// signed compare, result is 0 or 1
			rvCorePkg::aluSlt:   aluResult = {31'b0, $signed(rs1Data) < $signed(operandB)};
			// shift amount from the low five bits
			rvCorePkg::aluSll:   aluResult = rs1Data << operandB[4:0];
			rvCorePkg::aluSrl:   aluResult = rs1Data >> operandB[4:0];
			rvCorePkg::aluSra:   aluResult = $signed(rs1Data) >>> operandB[4:0];
			rvCorePkg::aluPassB: aluResult = operandB;
			default:             aluResult = '0;
		endcase
	end

	// beq taken on equal, bne on not equal
	assign branchTaken = isBranch & ((rs1Data == rs2Data) ^ branchNe);

	// return address for jal / jalr
	assign linkAddr = pc + 32'd4;

	// jalr target, bit 0 dropped
	assign jalrTarget = (rs1Data + imm) & ~32'd1;

	// next pc select
	always_comb begin
		if (isJalr)
			nextPc = jalrTarget;
		else if (isJal || branchTaken)
			nextPc = pc + imm;
		else
			nextPc = linkAddr;
	end

	// pc register, frozen by halt
	always_ff @(posedge CLK) begin
		if (RSTn)
			pc <= '0;
		else if (!halt)
			pc <= nextPc;
	end

	// imem takes a byte address, dmem a word address
	assign iMemAddr = pc[11:0];
	assign dMemAddr = aluResult[13:2];

endmodule

// File: logic/riscvResult.sv
`timescale 1ns/1ps

module riscvResult (
	input  logic             CLK,
	input  logic             RSTn,
	input  rvIsaPkg::instrT  instr,
	input  rvCorePkg::wordT  aluResult,
	input  rvCorePkg::wordT  linkAddr,
	input  rvCorePkg::wordT  rs2Data,
	input  rvCorePkg::wordT  dMemDi,
	input  rvCorePkg::wbSrcT wbSrc,
	input  logic             regWrite,
	input  logic             isStore,
	output logic             rfWe,
	output rvCorePkg::wordT  rfWd,
	output rvCorePkg::wordT  dMemDout,
	output logic             dMemWen,
	output logic [3:0]       dMemBe,
	output logic             iMemCsn,
	output logic             dMemCsn,
	output logic             halt,
	output rvCorePkg::countT numInst
);

	// previous retired instruction was the first halt word
	logic prevHaltFirst;
	// core active this cycle
	logic retire;

	// write-back data select
	always_comb begin
		case (wbSrc)
			rvCorePkg::wbMem:  rfWd = dMemDi;
			rvCorePkg::wbLink: rfWd = linkAddr;
			default:           rfWd = aluResult;
		endcase
	end

	// second halt word right after a retired first one
	assign halt = prevHaltFirst & (instr == rvIsaPkg::haltSecond);

	assign retire = ~RSTn & ~halt;

	// both memories deselected while in reset
	assign iMemCsn = RSTn;
	assign dMemCsn = RSTn;

	// register write, blocked in reset and after halt
	assign rfWe = regWrite & retire;

	// store side, word stores only so all lanes on
	assign dMemDout = rs2Data;
	assign dMemBe   = 4'b1111;
	// active low write enable
	assign dMemWen  = ~(isStore & retire);

	// halt history
	always_ff @(posedge CLK) begin
		if (RSTn)
			prevHaltFirst <= 1'b0;
		else if (!halt)
			prevHaltFirst <= (instr == rvIsaPkg::haltFirst);
	end

	// one count per retiring edge
	always_ff @(posedge CLK) begin
		if (RSTn)
			numInst <= '0;
		else if (!halt)
			numInst <= numInst + 1'b1;
	end

endmodule

// File: logic/regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic              CLK,
	input  logic              RSTn,
	input  rvCorePkg::regIdxT ra1,
	input  rvCorePkg::regIdxT ra2,
	input  rvCorePkg::regIdxT wa,
	input  logic              we,
	input  rvCorePkg::wordT   wd,
	output rvCorePkg::wordT   rd1,
	output rvCorePkg::wordT   rd2
);

	rvCorePkg::wordT regs [32];

	// sync write, reset wipes the whole file
	always_ff @(posedge CLK) begin
		if (RSTn) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (we && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// async reads, x0 hardwired to zero
	assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

// File: logic/riscvTop.sv
`timescale 1ns/1ps

module riscvTop (
	input  logic               CLK,
	input  logic               RSTn,
	output logic               iMemCsn,
	output rvCorePkg::memAddrT iMemAddr,
	input  rvIsaPkg::instrT    iMemDi,
	output logic               dMemCsn,
	output rvCorePkg::memAddrT dMemAddr,
	output rvCorePkg::wordT    dMemDout,
	output logic               dMemWen,
	output logic [3:0]         dMemBe,
	input  rvCorePkg::wordT    dMemDi,
	output logic               rfWe,
	output rvCorePkg::wordT    outputPort,
	output logic               halt,
	output rvCorePkg::countT   numInst
);

	// decode outputs
	rvCorePkg::regIdxT rs1;
	rvCorePkg::regIdxT rs2;
	rvCorePkg::regIdxT rd;
	rvCorePkg::wordT   imm;
	rvCorePkg::aluOpT  aluOp;
	rvCorePkg::wbSrcT  wbSrc;
	logic              useImm;
	logic              isLoad;
	logic              isStore;
	logic              isBranch;
	logic              branchNe;
	logic              isJal;
	logic              isJalr;
	logic              regWrite;

	// register reads
	rvCorePkg::wordT rs1Data;
	rvCorePkg::wordT rs2Data;

	// execute outputs
	rvCorePkg::wordT aluResult;
	rvCorePkg::wordT linkAddr;

	riscvDecode uDecode (
		.instr    (iMemDi),
		.rs1      (rs1),
		.rs2      (rs2),
		.rd       (rd),
		.imm      (imm),
		.aluOp    (aluOp),
		.useImm   (useImm),
		.isLoad   (isLoad),
		.isStore  (isStore),
		.isBranch (isBranch),
		.branchNe (branchNe),
		.isJal    (isJal),
		.isJalr   (isJalr),
		.regWrite (regWrite),
		.wbSrc    (wbSrc)
	);

	// write data doubles as the observation port
	regFile uRegFile (
		.CLK  (CLK),
		.RSTn (RSTn),
		.ra1  (rs1),
		.ra2  (rs2),
		.wa   (rd),
		.we   (rfWe),
		.wd   (outputPort),
		.rd1  (rs1Data),
		.rd2  (rs2Data)
	);

	// loads add the offset through isLoad
	// pc only reaches the memories through iMemAddr
	riscvExecute uExecute (
		.CLK       (CLK),
		.RSTn      (RSTn),
		.halt      (halt),
		.rs1Data   (rs1Data),
		.rs2Data   (rs2Data),
		.imm       (imm),
		.aluOp     (aluOp),
		.useImm    (useImm | isLoad),
		.isBranch  (isBranch),
		.branchNe  (branchNe),
		.isJal     (isJal),
		.isJalr    (isJalr),
		.pc        (),
		.aluResult (aluResult),
		.linkAddr  (linkAddr),
		.iMemAddr  (iMemAddr),
		.dMemAddr  (dMemAddr)
	);

	riscvResult uResult (
		.CLK       (CLK),
		.RSTn      (RSTn),
		.instr     (iMemDi),
		.aluResult (aluResult),
		.linkAddr  (linkAddr),
		.rs2Data   (rs2Data),
		.dMemDi    (dMemDi),
		.wbSrc     (wbSrc),
		.regWrite  (regWrite),
		.isStore   (isStore),
		.rfWe      (rfWe),
		.rfWd      (outputPort),
		.dMemDout  (dMemDout),
		.dMemWen   (dMemWen),
		.dMemBe    (dMemBe),
		.iMemCsn   (iMemCsn),
		.dMemCsn   (dMemCsn),
		.halt      (halt),
		.numInst   (numInst)
	);

endmodule

// File: verification/tbClock.sv
`timescale 1ns/1ps

module tbClock (
	output logic CLK,
	output logic RSTn
);

	// 8 ns period
	localparam int halfPeriod = 4;

	initial begin
		CLK  = 1'b0;
		RSTn = 1'b1;
		forever #halfPeriod CLK = ~CLK;
	end

	// three reset cycles, released on a falling edge
	initial begin
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		RSTn <= 1'b0;
	end

endmodule

// File: verification/riscvTop_props.sv
`timescale 1ns/1ps

module riscvTop_props (
	input logic             CLK,
	input logic             RSTn,
	input logic             iMemCsn,
	input logic             dMemCsn,
	input logic             dMemWen,
	input logic             rfWe,
	input logic             halt,
	input rvCorePkg::countT numInst
);

	// no register or memory write once halted
	haltBlocksWrites: assert property (@(posedge CLK) disable iff (RSTn)
		halt |-> (!rfWe && dMemWen))
		else $error("write enable active while halt is high");

	// both memories deselected in reset
	resetDeselects: assert property (@(posedge CLK) RSTn |-> (iMemCsn && dMemCsn))
		else $error("chip select low while reset is asserted");

	// counter frozen by halt
	haltHoldsCount: assert property (@(posedge CLK) disable iff (RSTn)
		halt |=> $stable(numInst))
		else $error("retired count moved while halted");

endmodule

bind riscvTop riscvTop_props uProps (
	.CLK     (CLK),
	.RSTn    (RSTn),
	.iMemCsn (iMemCsn),
	.dMemCsn (dMemCsn),
	.dMemWen (dMemWen),
	.rfWe    (rfWe),
	.halt    (halt),
	.numInst (numInst)
);

// File: verification/riscvTb.sv
`timescale 1ns/1ps

module riscvTb;

	// sample a little after the falling edge
	localparam int sampleSkew = 1;
	localparam int imemWords  = 256;
	localparam int dmemWords  = 4096;
	localparam rvCorePkg::wordT luiValue = 32'h1234_5000;

	logic               CLK;
	logic               RSTn;
	logic               iMemCsn;
	rvCorePkg::memAddrT iMemAddr;
	rvIsaPkg::instrT    iMemDi;
	logic               dMemCsn;
	rvCorePkg::memAddrT dMemAddr;
	rvCorePkg::wordT    dMemDout;
	logic               dMemWen;
	logic [3:0]         dMemBe;
	rvCorePkg::wordT    dMemDi;
	logic               rfWe;
	rvCorePkg::wordT    outputPort;
	logic               halt;
	rvCorePkg::countT   numInst;

	// 1 KB program store, data store plus its reference copy
	rvIsaPkg::instrT instrMem [imemWords];
	rvCorePkg::wordT dataMem [dmemWords];
	rvCorePkg::wordT dataRef [dmemWords];

	// program table, one entry per checked cycle
	string              stepName [$];
	rvIsaPkg::instrT    stepInstr [$];
	rvCorePkg::memAddrT stepAddr [$];
	logic               stepWe [$];
	logic               stepWenLow [$];
	rvCorePkg::wordT    stepData [$];

	int numSteps   = 0;
	int errorCount = 0;
	int checkTotal = 0;
	int cycleCount = 0;

	tbClock uClock (
		.CLK  (CLK),
		.RSTn (RSTn)
	);

	riscvTop DUT (
		.CLK        (CLK),
		.RSTn       (RSTn),
		.iMemCsn    (iMemCsn),
		.iMemAddr   (iMemAddr),
		.iMemDi     (iMemDi),
		.dMemCsn    (dMemCsn),
		.dMemAddr   (dMemAddr),
		.dMemDout   (dMemDout),
		.dMemWen    (dMemWen),
		.dMemBe     (dMemBe),
		.dMemDi     (dMemDi),
		.rfWe       (rfWe),
		.outputPort (outputPort),
		.halt       (halt),
		.numInst    (numInst)
	);

	// both memories answer in the same cycle
	assign iMemDi = instrMem[iMemAddr[9:2]];
	assign dMemDi = dataMem[dMemAddr];

	function automatic rvCorePkg::wordT mergeBytes(input rvCorePkg::wordT old,
			input rvCorePkg::wordT data, input logic [3:0] be);
		rvCorePkg::wordT merged;
		merged = old;
		for (int b = 0; b < 4; b++) begin
			if (be[b])
				merged[8*b +: 8] = data[8*b +: 8];
		end
		return merged;
	endfunction

	// store on the rising edge, wen and csn active low
	always @(posedge CLK) begin
		if (!dMemCsn && !dMemWen)
			dataMem[dMemAddr] <= mergeBytes(dataMem[dMemAddr], dMemDout, dMemBe);
	end

	// RV32I encoders, one per format
	function automatic rvIsaPkg::instrT encR(input logic [6:0] f7, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, rvIsaPkg::opR};
	endfunction

	function automatic rvIsaPkg::instrT encI(input logic [11:0] imm, input logic [4:0] rs1,
			input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	function automatic rvIsaPkg::instrT encS(input logic [11:0] imm, input logic [4:0] rs2,
			input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, rvIsaPkg::f3Sw, imm[4:0], rvIsaPkg::opStore};
	endfunction

	// offset bit 0 is implied
	function automatic rvIsaPkg::instrT encB(input logic [12:0] off, input logic [4:0] rs2,
			input logic [4:0] rs1, input logic [2:0] f3);
		return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], rvIsaPkg::opBranch};
	endfunction

	function automatic rvIsaPkg::instrT encJ(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, rvIsaPkg::opJal};
	endfunction

	function automatic rvIsaPkg::instrT encU(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, rvIsaPkg::opLui};
	endfunction

	task automatic checkWord(input string name, input rvCorePkg::wordT expected,
			input rvCorePkg::wordT actual);
		checkTotal++;
		if (actual !== expected) begin
			errorCount++;
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic checkAddr(input string name, input rvCorePkg::memAddrT expected,
			input rvCorePkg::memAddrT actual);
		checkTotal++;
		if (actual !== expected) begin
			errorCount++;
			$display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic checkFlag(input string name, input logic expected, input logic actual);
		checkTotal++;
		if (actual !== expected) begin
			errorCount++;
			$display("[ERROR] %s: expected %b, actual %b", name, expected, actual);
		end
	endtask

	task automatic checkCount(input string name, input rvCorePkg::countT expected,
			input rvCorePkg::countT actual);
		checkTotal++;
		if (actual !== expected) begin
			errorCount++;
			$display("[ERROR] %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	// table row, also placed in the program store at its address
	task automatic addStep(input string name, input rvIsaPkg::instrT instr,
			input rvCorePkg::memAddrT addr, input logic we, input logic wenLow,
			input rvCorePkg::wordT data);
		stepName.push_back(name);
		stepInstr.push_back(instr);
		stepAddr.push_back(addr);
		stepWe.push_back(we);
		stepWenLow.push_back(wenLow);
		stepData.push_back(data);
		instrMem[addr[9:2]] = instr;
	endtask

	task automatic fillMemories();
		// skipped slots hold addi x31, x0, slot index
		for (int i = 0; i < imemWords; i++)
			instrMem[i] = encI(12'(i), 5'd0, rvIsaPkg::f3Add, 5'd31, rvIsaPkg::opI);
		for (int i = 0; i < dmemWords; i++) begin
			dataMem[i] = $urandom();
			dataRef[i] = dataMem[i];
		end
	endtask

	task automatic buildProgram();
		// x1 = 5, x2 = -3 feed the alu rows
		addStep("addi x1", encI(12'd5, 5'd0, rvIsaPkg::f3Add, 5'd1, rvIsaPkg::opI),
			12'd0, 1'b1, 1'b0, 32'h0000_0005);
		addStep("addi x2", encI(12'hffd, 5'd0, rvIsaPkg::f3Add, 5'd2, rvIsaPkg::opI),
			12'd4, 1'b1, 1'b0, 32'hffff_fffd);
		addStep("add", encR(7'd0, 5'd2, 5'd1, rvIsaPkg::f3Add, 5'd3),
			12'd8, 1'b1, 1'b0, 32'h0000_0002);
		addStep("sub", encR(rvIsaPkg::funct7Alt, 5'd2, 5'd1, rvIsaPkg::f3Add, 5'd4),
			12'd12, 1'b1, 1'b0, 32'h0000_0008);
		addStep("and", encR(7'd0, 5'd2, 5'd1, rvIsaPkg::f3And, 5'd5),
			12'd16, 1'b1, 1'b0, 32'h0000_0005);
		addStep("or", encR(7'd0, 5'd2, 5'd1, rvIsaPkg::f3Or, 5'd6),
			12'd20, 1'b1, 1'b0, 32'hffff_fffd);
		addStep("xor", encR(7'd0, 5'd2, 5'd1, rvIsaPkg::f3Xor, 5'd7),
			12'd24, 1'b1, 1'b0, 32'hffff_fff8);
		// -3 < 5 signed
		addStep("slt", encR(7'd0, 5'd1, 5'd2, rvIsaPkg::f3Slt, 5'd8),
			12'd28, 1'b1, 1'b0, 32'h0000_0001);
		addStep("sll", encR(7'd0, 5'd1, 5'd1, rvIsaPkg::f3Sll, 5'd9),
			12'd32, 1'b1, 1'b0, 32'h0000_00a0);
		addStep("srl", encR(7'd0, 5'd1, 5'd2, rvIsaPkg::f3Srl, 5'd10),
			12'd36, 1'b1, 1'b0, 32'h07ff_ffff);
		addStep("sra", encR(rvIsaPkg::funct7Alt, 5'd1, 5'd2, rvIsaPkg::f3Srl, 5'd11),
			12'd40, 1'b1, 1'b0, 32'hffff_ffff);
		addStep("lui", encU(20'h12345, 5'd12), 12'd44, 1'b1, 1'b0, luiValue);
		// result dropped by x0
		addStep("addi x0", encI(12'd7, 5'd1, rvIsaPkg::f3Add, 5'd0, rvIsaPkg::opI),
			12'd48, 1'b1, 1'b0, 32'h0000_000c);
		addStep("read x0", encR(7'd0, 5'd1, 5'd0, rvIsaPkg::f3Add, 5'd13),
			12'd52, 1'b1, 1'b0, 32'h0000_0005);
		addStep("andi", encI(12'h0f0, 5'd6, rvIsaPkg::f3And, 5'd14, rvIsaPkg::opI),
			12'd56, 1'b1, 1'b0, 32'h0000_00f0);
		addStep("ori", encI(12'h100, 5'd5, rvIsaPkg::f3Or, 5'd15, rvIsaPkg::opI),
			12'd60, 1'b1, 1'b0, 32'h0000_0105);
		addStep("xori", encI(12'hfff, 5'd1, rvIsaPkg::f3Xor, 5'd16, rvIsaPkg::opI),
			12'd64, 1'b1, 1'b0, 32'hffff_fffa);
		addStep("slti", encI(12'hffe, 5'd2, rvIsaPkg::f3Slt, 5'd17, rvIsaPkg::opI),
			12'd68, 1'b1, 1'b0, 32'h0000_0001);
		addStep("addi x18", encI(12'h040, 5'd0, rvIsaPkg::f3Add, 5'd18, rvIsaPkg::opI),
			12'd72, 1'b1, 1'b0, 32'h0000_0040);
		// byte 0x48 is data word 0x12
		addStep("sw", encS(12'd8, 5'd12, 5'd18), 12'd76, 1'b0, 1'b1, 32'h0);
		addStep("lw stored", encI(12'd8, 5'd18, rvIsaPkg::f3Lw, 5'd19, rvIsaPkg::opLoad),
			12'd80, 1'b1, 1'b0, luiValue);
		addStep("lw seeded", encI(12'h100, 5'd0, rvIsaPkg::f3Lw, 5'd20, rvIsaPkg::opLoad),
			12'd84, 1'b1, 1'b0, dataRef[12'h040]);
		// taken, taken, not taken, not taken
		addStep("beq taken", encB(13'd8, 5'd13, 5'd1, rvIsaPkg::f3Beq),
			12'd88, 1'b0, 1'b0, 32'h0);
		addStep("bne taken", encB(13'd8, 5'd2, 5'd1, rvIsaPkg::f3Bne),
			12'd96, 1'b0, 1'b0, 32'h0);
		addStep("bne fall", encB(13'd12, 5'd13, 5'd1, rvIsaPkg::f3Bne),
			12'd104, 1'b0, 1'b0, 32'h0);
		addStep("beq fall", encB(-13'd100, 5'd2, 5'd1, rvIsaPkg::f3Beq),
			12'd108, 1'b0, 1'b0, 32'h0);
		addStep("jal", encJ(21'd12, 5'd21), 12'd112, 1'b1, 1'b0, 32'h0000_0074);
		addStep("addi x22", encI(12'd140, 5'd0, rvIsaPkg::f3Add, 5'd22, rvIsaPkg::opI),
			12'd124, 1'b1, 1'b0, 32'h0000_008c);
		addStep("jalr", encI(12'd0, 5'd22, rvIsaPkg::f3Jalr, 5'd23, rvIsaPkg::opJalr),
			12'd128, 1'b1, 1'b0, 32'h0000_0084);
		addStep("halt first", rvIsaPkg::haltFirst, 12'd140, 1'b1, 1'b0, 32'h0000_000c);
		addStep("halt second", rvIsaPkg::haltSecond, 12'd144, 1'b0, 1'b0, 32'h0);
		// frozen on the same word
		addStep("halt hold 1", rvIsaPkg::haltSecond, 12'd144, 1'b0, 1'b0, 32'h0);
		addStep("halt hold 2", rvIsaPkg::haltSecond, 12'd144, 1'b0, 1'b0, 32'h0);
	endtask

	task automatic checkMemory();
		checkWord("sw target word", luiValue, dataMem[12'h012]);
		// every other word untouched
		for (int i = 0; i < dmemWords; i++) begin
			if (i != 'h12 && dataMem[i] !== dataRef[i])
				checkWord($sformatf("untouched word %0h", i), dataRef[i], dataMem[i]);
		end
	endtask

	initial begin
		logic             prevFirst;
		logic             haltExp;
		rvCorePkg::countT retired;
		void'($urandom(25));
		fillMemories();
		buildProgram();
		numSteps  = stepName.size();
		prevFirst = 1'b0;
		retired   = '0;

		// inside the reset window
		@(negedge CLK);
		#sampleSkew;
		checkFlag("reset iMemCsn", 1'b1, iMemCsn);
		checkFlag("reset dMemCsn", 1'b1, dMemCsn);
		checkFlag("reset dMemWen", 1'b1, dMemWen);
		checkFlag("reset rfWe", 1'b0, rfWe);
		checkCount("reset numInst", '0, numInst);

		wait (RSTn == 1'b0);
		for (int k = 0; k < numSteps; k++) begin
			if (k > 0)
				@(negedge CLK);
			#sampleSkew;
			// halt pair, history only moves on a retired word
			haltExp = prevFirst && (stepInstr[k] == rvIsaPkg::haltSecond);
			checkAddr(stepName[k], stepAddr[k], iMemAddr);
			checkFlag({stepName[k], " rfWe"}, stepWe[k], rfWe);
			// write-back value only counts with rfWe
			if (stepWe[k])
				checkWord(stepName[k], stepData[k], outputPort);
			checkFlag({stepName[k], " dMemWen"}, !stepWenLow[k], dMemWen);
			checkFlag({stepName[k], " halt"}, haltExp, halt);
			checkCount({stepName[k], " numInst"}, retired, numInst);
			if (!haltExp) begin
				prevFirst = (stepInstr[k] == rvIsaPkg::haltFirst);
				retired++;
			end
		end
		checkMemory();

		$display("%0d checks, %0d errors", checkTotal, errorCount);
		if (errorCount == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	// cycle limit sized from the table length
	initial begin
		wait (numSteps > 0);
		while (cycleCount < 2 * numSteps + 20) begin
			@(posedge CLK);
			cycleCount++;
		end
		$display("timeout: the program table did not finish within %0d cycles", cycleCount);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: sim.f
logic/rvIsaPkg.sv
logic/rvCorePkg.sv
logic/riscvDecode.sv
logic/riscvExecute.sv
logic/riscvResult.sv
logic/regFile.sv
logic/riscvTop.sv
verification/tbClock.sv
verification/riscvTop_props.sv
verification/riscvTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = riscvTb
FILELIST  = sim.f
OBJDIR    = obj_dir
PASSMSG   = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the status comes from the search for the pass line
run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)
